// File: src.f
+incdir+rtl
rtl/riscvPkg.sv
rtl/immExtend.sv
rtl/instrDecoder.sv
rtl/alu.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/riscvPipeline.sv
test/riscvPipeline_checker.sv
test/riscvPipeline_tb.sv

// File: test/riscvPipeline_tb.sv
`timescale 1ns/100ps
`include "riscv_consts.svh"

module riscvPipeline_tb
  import riscvPkg::*;
();

  localparam int SEED = 20633;
  localparam int PROG_LEN = 120;
  localparam int PROG_WORDS = 256;
  localparam int RESET_CYCLES = 10;

  typedef enum {opAdd, opSub, opAnd, opOr, opSlt, opAddi, opAndi, opOri, opSlti,
                opLw, opSw, opBeq, opJal} kindT;
  typedef struct {
    kindT kind;
    int   rd;
    int   rs1;
    int   rs2;
    int   imm;   // byte offset for memory and control flow
  } insnT;

  logic clk = 1'b0;
  logic reset;
  wordT instr, readData, pc, dataAdr, writeData;
  logic memWrite;

  insnT prog[$];
  wordT progMem[PROG_WORDS];
  wordT dmem[`DMEM_WORDS];
  wordT expAdr[$];
  wordT expData[$];
  int   expCount;
  int   storeCount = 0;
  logic running = 1'b0;

  riscvPipeline u_dut (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .instr     (instr),
    .memWrite  (memWrite),
    .dataAdr   (dataAdr),
    .writeData (writeData),
    .readData  (readData)
  );

  always #4 clk = ~clk;   // 8 ns period

  task automatic failRun(string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compareWord(string name, wordT expected, wordT actual);
    if (actual !== expected)
      failRun($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic compareAddr(string name, wordT expected, wordT actual);
    if (actual !== expected)
      failRun($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
  endtask

  // every word of the initial data memory differs
  function automatic wordT fillWord(int idx);
    return wordT'(idx) * 32'h0019_660D + 32'h3C6E_F35F;
  endfunction

  function automatic int memIndex(wordT adr);
    if ($isunknown(adr))
      return 0;
    return int'(adr >> 2) % `DMEM_WORDS;
  endfunction

  function automatic insnT makeInsn(kindT kind, int rd, int rs1, int rs2, int imm);
    insnT ins;
    ins.kind = kind;
    ins.rd = rd;
    ins.rs1 = rs1;
    ins.rs2 = rs2;
    ins.imm = imm;
    return ins;
  endfunction

  function automatic int randImm12();
    return int'($urandom % 4096) - 2048;
  endfunction

  function automatic wordT encode(insnT ins);
    logic [11:0] i12;
    logic [12:0] b13;
    logic [20:0] j21;
    logic [4:0]  rd, rs1, rs2;
    i12 = ins.imm[11:0];
    b13 = ins.imm[12:0];
    j21 = ins.imm[20:0];
    rd = ins.rd[4:0];
    rs1 = ins.rs1[4:0];
    rs2 = ins.rs2[4:0];
    case (ins.kind)
      opAdd:   return {7'b0000000, rs2, rs1, `F3_ADDSUB, rd, `OP_RTYPE};
      opSub:   return {7'b0100000, rs2, rs1, `F3_ADDSUB, rd, `OP_RTYPE};
      opAnd:   return {7'b0000000, rs2, rs1, `F3_AND, rd, `OP_RTYPE};
      opOr:    return {7'b0000000, rs2, rs1, `F3_OR, rd, `OP_RTYPE};
      opSlt:   return {7'b0000000, rs2, rs1, `F3_SLT, rd, `OP_RTYPE};
      opAddi:  return {i12, rs1, `F3_ADDSUB, rd, `OP_ITYPE};
      opAndi:  return {i12, rs1, `F3_AND, rd, `OP_ITYPE};
      opOri:   return {i12, rs1, `F3_OR, rd, `OP_ITYPE};
      opSlti:  return {i12, rs1, `F3_SLT, rd, `OP_ITYPE};
      opLw:    return {i12, rs1, 3'b010, rd, `OP_LOAD};   // word width
      opSw:    return {i12[11:5], rs2, rs1, 3'b010, i12[4:0], `OP_STORE};
      opBeq:   return {b13[12], b13[10:5], rs2, rs1, 3'b000, b13[4:1], b13[11], `OP_BRANCH};
      opJal:   return {j21[20], j21[10:1], j21[11], j21[19:12], rd, `OP_JAL};
      default: return '0;
    endcase
  endfunction

  // few registers in use, so dependences are dense
  task automatic buildProgram();
    int rd, rs1, rs2, room, hop, sel;
    for (int r = 1; r <= 7; r++)
      prog.push_back(makeInsn(opAddi, r, 0, 0, randImm12()));
    while (prog.size() < PROG_LEN) begin
      rd = 1 + $urandom % 7;
      rs1 = $urandom % 8;
      rs2 = $urandom % 8;
      room = PROG_LEN - prog.size();   // targets stop at the epilogue
      hop = `PC_STEP * (1 + $urandom % ((room < 4) ? room : 4));
      sel = $urandom % 16;
      case (sel)
        0, 1, 2, 3, 4: prog.push_back(makeInsn(kindT'(sel), rd, rs1, rs2, 0));
        5, 6, 7, 8: prog.push_back(makeInsn(kindT'(sel), rd, rs1, 0, randImm12()));
        9, 10: begin
          prog.push_back(makeInsn(opLw, rd, 0, 0, 4 * ($urandom % `DMEM_WORDS)));
          if (($urandom % 2) == 1 && prog.size() < PROG_LEN)   // load-use pair
            prog.push_back(makeInsn(opAdd, 1 + $urandom % 7, rd, rs2, 0));
        end
        11, 12: prog.push_back(makeInsn(opSw, 0, 0, rs2, 4 * ($urandom % `DMEM_WORDS)));
        13, 14: prog.push_back(makeInsn(opBeq, 0, rs1, ($urandom % 2) ? rs1 : rs2, hop));
        default: prog.push_back(makeInsn(opJal, rd, 0, 0, hop));
      endcase
    end
    for (int r = 1; r < `REG_COUNT; r++)
      prog.push_back(makeInsn(opSw, 0, 0, r, 4 * r));   // register dump
  endtask

  // program-order reference, collects the expected stores
  task automatic runModel();
    wordT regs[`REG_COUNT];
    wordT mem[`DMEM_WORDS];
    wordT a, b;
    insnT ins;
    int   i, next;
    foreach (regs[r])
      regs[r] = '0;
    foreach (mem[m])
      mem[m] = fillWord(m);
    i = 0;
    while (i < prog.size()) begin
      ins = prog[i];
      a = regs[ins.rs1];
      b = regs[ins.rs2];
      next = i + 1;
      case (ins.kind)
        opAdd:  regs[ins.rd] = a + b;
        opSub:  regs[ins.rd] = a - b;
        opAnd:  regs[ins.rd] = a & b;
        opOr:   regs[ins.rd] = a | b;
        opSlt:  regs[ins.rd] = ($signed(a) < $signed(b)) ? wordT'(1) : wordT'(0);
        opAddi: regs[ins.rd] = a + wordT'(ins.imm);
        opAndi: regs[ins.rd] = a & wordT'(ins.imm);
        opOri:  regs[ins.rd] = a | wordT'(ins.imm);
        opSlti: regs[ins.rd] = ($signed(a) < ins.imm) ? wordT'(1) : wordT'(0);
        opLw:   regs[ins.rd] = mem[ins.imm / 4];
        opSw: begin
          mem[ins.imm / 4] = b;
          expAdr.push_back(wordT'(ins.imm));
          expData.push_back(b);
        end
        opBeq: begin
          if (a == b)
            next = i + ins.imm / `PC_STEP;
        end
        opJal: begin
          regs[ins.rd] = wordT'(i * `PC_STEP + `PC_STEP);   // link
          next = i + ins.imm / `PC_STEP;
        end
        default: ;
      endcase
      regs[0] = '0;
      i = next;
    end
    expCount = expAdr.size();
  endtask

  // memory models answer on the falling edge, stores checked in order
  always @(negedge clk) begin
    if (memWrite === 1'b1) begin
      if (storeCount >= expCount)
        failRun($sformatf("store to %h beyond the %0d stores of the model", dataAdr, expCount));
      compareAddr($sformatf("store %0d address", storeCount), expAdr[storeCount], dataAdr);
      compareWord($sformatf("store %0d data", storeCount), expData[storeCount], writeData);
      dmem[memIndex(dataAdr)] = writeData;
      storeCount++;
    end
    instr <= ((pc >> 2) < PROG_WORDS) ? progMem[pc >> 2] : '0;
    readData <= dmem[memIndex(dataAdr)];
  end

  always @(negedge clk) begin
    if (u_dut.u_checker.failCount != 0)
      failRun("an assertion in the bound checker failed");
  end

  initial begin
    wait (running);
    repeat (prog.size() * 3 + 50) @(posedge clk);
    failRun($sformatf("timeout: core stopped making progress after %0d of %0d stores",
                      storeCount, expCount));
  end

  initial begin
    reset = 1'b1;
    instr = '0;
    readData = '0;
    void'($urandom(SEED));
    buildProgram();
    runModel();
    foreach (progMem[k])
      progMem[k] = (k < prog.size()) ? encode(prog[k]) : '0;
    foreach (dmem[m])
      dmem[m] = fillWord(m);
    repeat (RESET_CYCLES) @(negedge clk);
    reset <= 1'b0;
    compareAddr("pc after reset", wordT'(0), pc);   // fetch starts at address zero
    running = 1'b1;
    wait (storeCount == expCount);
    repeat (10) @(negedge clk);   // room for stray stores
    if (storeCount == expCount) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      failRun($sformatf("DUT made %0d stores, model expects %0d", storeCount, expCount));
    end
  end

endmodule

// File: test/riscvPipeline_checker.sv
`timescale 1ns/100ps
`include "riscv_consts.svh"

module riscvPipeline_checker
  import riscvPkg::*;
(
  input logic clk,
  input logic reset,
  input wordT pc,
  input logic memWrite,
  input wordT dataAdr
);

  int failCount = 0;

  // quiet through reset and the first cycle after it
  noStoreNearReset: assert property (@(posedge clk) reset |=> !memWrite [*2])
    else begin
      $error("memWrite high during reset or in the first cycle after it");
      failCount++;
    end

  pcAligned: assert property (@(posedge clk) disable iff (reset) (pc % `PC_STEP) == 0)
    else begin
      $error("pc %h is not a multiple of the instruction step", pc);
      failCount++;
    end

  storeAligned: assert property (@(posedge clk) disable iff (reset)
    memWrite |-> (dataAdr[1:0] == 2'b00))
    else begin
      $error("store to unaligned address %h", dataAdr);
      failCount++;
    end

endmodule

bind riscvPipeline riscvPipeline_checker u_checker (
  .clk      (clk),
  .reset    (reset),
  .pc       (pc),
  .memWrite (memWrite),
  .dataAdr  (dataAdr)
);

// File: rtl/riscvPipeline.sv
`timescale 1ns/100ps
`include "riscv_consts.svh"

module riscvPipeline
  import riscvPkg::*;
(
  input  logic clk,
  input  logic reset,
  output wordT pc,
  input  wordT instr,
  output logic memWrite,
  output wordT dataAdr,
  output wordT writeData,
  input  wordT readData
);

  // fetch
  wordT pcPlus4F;
  wordT pcNext;
  // decode
  wordT instrD, pcD, pcPlus4D;
  regAddrT rs1D, rs2D, rdD;
  wordT rd1D, rd2D, immD;
  logic regWriteD, memWriteD, jumpD, branchD, aluSrcD;
  resultSrcT resultSrcD;
  aluOpT aluOpD;
  // execute
  logic regWriteE, memWriteE, jumpE, branchE, aluSrcE;
  resultSrcT resultSrcE;
  aluOpT aluOpE;
  regAddrT rs1E, rs2E, rdE;
  wordT rd1E, rd2E, pcE, immE, pcPlus4E;
  wordT srcAE, srcBE, writeDataE, aluResultE, pcTargetE;
  logic zeroE, branchTakenE, loadE;
  // memory
  logic regWriteM, memWriteM;
  resultSrcT resultSrcM;
  regAddrT rdM;
  wordT aluResultM, writeDataM, pcPlus4M;
  // writeback
  logic regWriteW;
  resultSrcT resultSrcW;
  regAddrT rdW;
  wordT aluResultW, readDataW, pcPlus4W, resultW;
  // hazards
  logic stall, flushD, flushE;
  forwardSelT forwardA, forwardB;

  function automatic wordT forwardMux(forwardSelT sel, wordT regVal, wordT memVal, wordT wbVal);
    case (sel)
      fwdMem:  return memVal;
      fwdWb:   return wbVal;
      default: return regVal;
    endcase
  endfunction

  assign pcPlus4F = pc + `PC_STEP;
  assign pcNext = branchTakenE ? pcTargetE : pcPlus4F;

  always_ff @(posedge clk) begin
    if (reset)
      pc <= '0;
    else if (!stall)
      pc <= pcNext;
  end

  always_ff @(posedge clk) begin
    if (reset || flushD)
      instrD <= '0;   // zero word decodes as a bubble
    else if (!stall)
      instrD <= instr;
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      pcD <= pc;
      pcPlus4D <= pcPlus4F;
    end
  end

  assign rs1D = instrD[19:15];
  assign rs2D = instrD[24:20];
  assign rdD = instrD[11:7];

  instrDecoder u_instrDecoder (
    .instr     (instrD),
    .regWrite  (regWriteD),
    .resultSrc (resultSrcD),
    .memWrite  (memWriteD),
    .jump      (jumpD),
    .branch    (branchD),
    .aluSrc    (aluSrcD),
    .aluOp     (aluOpD),
    .imm       (immD)
  );

  regFile u_regFile (
    .clk       (clk),
    .reset     (reset),
    .writeEn   (regWriteW),
    .readAddr1 (rs1D),
    .readAddr2 (rs2D),
    .writeAddr (rdW),
    .writeData (resultW),
    .readData1 (rd1D),
    .readData2 (rd2D)
  );

  // decode to execute, control and indices
  always_ff @(posedge clk) begin
    if (reset || flushE) begin
      regWriteE <= 1'b0;
      resultSrcE <= resultAlu;
      memWriteE <= 1'b0;
      jumpE <= 1'b0;
      branchE <= 1'b0;
      aluSrcE <= 1'b0;
      aluOpE <= aluAdd;
      rs1E <= '0;
      rs2E <= '0;
      rdE <= '0;
    end else begin
      regWriteE <= regWriteD;
      resultSrcE <= resultSrcD;
      memWriteE <= memWriteD;
      jumpE <= jumpD;
      branchE <= branchD;
      aluSrcE <= aluSrcD;
      aluOpE <= aluOpD;
      rs1E <= rs1D;
      rs2E <= rs2D;
      rdE <= rdD;
    end
  end

  always_ff @(posedge clk) begin
    rd1E <= rd1D;
    rd2E <= rd2D;
    pcE <= pcD;
    immE <= immD;
    pcPlus4E <= pcPlus4D;
  end

  assign srcAE = forwardMux(forwardA, rd1E, aluResultM, resultW);
  assign writeDataE = forwardMux(forwardB, rd2E, aluResultM, resultW);
  assign srcBE = aluSrcE ? immE : writeDataE;

  alu u_alu (
    .a      (srcAE),
    .b      (srcBE),
    .aluOp  (aluOpE),
    .result (aluResultE),
    .zero   (zeroE)
  );

  assign pcTargetE = pcE + immE;
  assign branchTakenE = (zeroE && branchE) || jumpE;
  assign loadE = (resultSrcE == resultMem);

  always_ff @(posedge clk) begin
    if (reset) begin
      regWriteM <= 1'b0;
      resultSrcM <= resultAlu;
      memWriteM <= 1'b0;
      rdM <= '0;
    end else begin
      regWriteM <= regWriteE;
      resultSrcM <= resultSrcE;
      memWriteM <= memWriteE;
      rdM <= rdE;
    end
  end

  always_ff @(posedge clk) begin
    aluResultM <= aluResultE;
    writeDataM <= writeDataE;
    pcPlus4M <= pcPlus4E;
  end

  assign memWrite = memWriteM;
  assign dataAdr = aluResultM;
  assign writeData = writeDataM;

  always_ff @(posedge clk) begin
    if (reset) begin
      regWriteW <= 1'b0;
      resultSrcW <= resultAlu;
      rdW <= '0;
    end else begin
      regWriteW <= regWriteM;
      resultSrcW <= resultSrcM;
      rdW <= rdM;
    end
  end

  always_ff @(posedge clk) begin
    aluResultW <= aluResultM;
    readDataW <= readData;   // load data at end of memory stage
    pcPlus4W <= pcPlus4M;
  end

  always_comb begin
    case (resultSrcW)
      resultMem:     resultW = readDataW;
      resultPcPlus4: resultW = pcPlus4W;
      default:       resultW = aluResultW;
    endcase
  end

  hazardUnit u_hazardUnit (
    .rs1D         (rs1D),
    .rs2D         (rs2D),
    .rs1E         (rs1E),
    .rs2E         (rs2E),
    .rdE          (rdE),
    .rdM          (rdM),
    .rdW          (rdW),
    .regWriteM    (regWriteM),
    .regWriteW    (regWriteW),
    .loadE        (loadE),
    .branchTakenE (branchTakenE),
    .stall        (stall),
    .flushD       (flushD),
    .flushE       (flushE),
    .forwardA     (forwardA),
    .forwardB     (forwardB)
  );

endmodule

// File: rtl/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit
  import riscvPkg::*;
(
  input  regAddrT    rs1D,
  input  regAddrT    rs2D,
  input  regAddrT    rs1E,
  input  regAddrT    rs2E,
  input  regAddrT    rdE,
  input  regAddrT    rdM,
  input  regAddrT    rdW,
  input  logic       regWriteM,
  input  logic       regWriteW,
  input  logic       loadE,
  input  logic       branchTakenE,
  output logic       stall,
  output logic       flushD,
  output logic       flushE,
  output forwardSelT forwardA,
  output forwardSelT forwardB
);

  // memory stage holds the younger result, so it wins
  function automatic forwardSelT pickForward(regAddrT rs);
    forwardSelT sel;
    sel = fwdNone;
    if (regWriteM && (rdM != '0) && (rdM == rs))
      sel = fwdMem;
    else if (regWriteW && (rdW != '0) && (rdW == rs))
      sel = fwdWb;
    return sel;
  endfunction

  always_comb begin
    forwardA = pickForward(rs1E);
    forwardB = pickForward(rs2E);
  end

  // load result not ready until writeback
  assign stall = loadE && (rdE != '0) && ((rdE == rs1D) || (rdE == rs2D));
  assign flushD = branchTakenE;
  assign flushE = branchTakenE || stall;   // bubble into execute

endmodule

// File: rtl/regFile.sv
`timescale 1ns/100ps
`include "riscv_consts.svh"

module regFile
  import riscvPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    writeEn,
  input  regAddrT readAddr1,
  input  regAddrT readAddr2,
  input  regAddrT writeAddr,
  input  wordT    writeData,
  output wordT    readData1,
  output wordT    readData2
);

  wordT regs [`REG_COUNT];

  // falling-edge write, so decode reads the writeback value in the same cycle
  always_ff @(negedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[writeAddr] <= writeData;
    end
  end

  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];   // x0 hardwired
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// File: rtl/alu.sv
`timescale 1ns/100ps
`include "riscv_consts.svh"

module alu
  import riscvPkg::*;
(
  input  wordT  a,
  input  wordT  b,
  input  aluOpT aluOp,
  output wordT  result,
  output logic  zero
);

  logic invB;
  wordT condInvB;
  wordT sum;
  logic overflow;
  logic lessThan;

  // one adder, b inverted plus carry-in for subtract and compare
  assign invB = (aluOp == aluSub) || (aluOp == aluSlt);
  assign condInvB = invB ? ~b : b;
  assign sum = a + condInvB + wordT'(invB);

  // adder inputs agree in sign but the sum does not
  assign overflow = ~(a[`XLEN-1] ^ condInvB[`XLEN-1]) & (a[`XLEN-1] ^ sum[`XLEN-1]);
  assign lessThan = sum[`XLEN-1] ^ overflow;   // signed a < b

  always_comb begin
    case (aluOp)
      aluAdd,
      aluSub:  result = sum;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluSlt:  result = {{(`XLEN-1){1'b0}}, lessThan};
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);   // beq uses this

endmodule

// File: rtl/instrDecoder.sv
`timescale 1ns/100ps
`include "riscv_consts.svh"

module instrDecoder
  import riscvPkg::*;
(
  input  wordT      instr,
  output logic      regWrite,
  output resultSrcT resultSrc,
  output logic      memWrite,
  output logic      jump,
  output logic      branch,
  output logic      aluSrc,
  output aluOpT     aluOp,
  output wordT      imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  immTypeT    immType;
  logic       useFunct;   // ALU class, op taken from funct3
  logic       forceSub;   // beq compares by subtracting
  logic       rtypeSub;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  // funct7 bit 5 means sub only for register-register ops
  assign rtypeSub = instr[30] && (opcode == `OP_RTYPE);

  // main decoder
  always_comb begin
    regWrite = 1'b0;
    resultSrc = resultAlu;
    memWrite = 1'b0;
    jump = 1'b0;
    branch = 1'b0;
    aluSrc = 1'b0;
    immType = immI;
    useFunct = 1'b0;
    forceSub = 1'b0;
    case (opcode)
      `OP_LOAD: begin
        regWrite = 1'b1;
        resultSrc = resultMem;
        aluSrc = 1'b1;   // base + offset
      end
      `OP_STORE: begin
        memWrite = 1'b1;
        aluSrc = 1'b1;
        immType = immS;
      end
      `OP_RTYPE: begin
        regWrite = 1'b1;
        useFunct = 1'b1;
      end
      `OP_ITYPE: begin
        regWrite = 1'b1;
        aluSrc = 1'b1;
        useFunct = 1'b1;
      end
      `OP_BRANCH: begin
        branch = 1'b1;
        immType = immB;
        forceSub = 1'b1;
      end
      `OP_JAL: begin
        regWrite = 1'b1;
        jump = 1'b1;
        resultSrc = resultPcPlus4;   // link value
        immType = immJ;
      end
      default: ;   // zero word and anything unknown stay a bubble
    endcase
  end

  // ALU operation decoder
  always_comb begin
    if (forceSub) begin
      aluOp = aluSub;
    end else if (!useFunct) begin
      aluOp = aluAdd;   // address generation
    end else begin
      case (funct3)
        `F3_ADDSUB: aluOp = rtypeSub ? aluSub : aluAdd;
        `F3_SLT:    aluOp = aluSlt;
        `F3_OR:     aluOp = aluOr;
        `F3_AND:    aluOp = aluAnd;
        default:    aluOp = aluAdd;
      endcase
    end
  end

  immExtend u_immExtend (
    .instr   (instr),
    .immType (immType),
    .imm     (imm)
  );

endmodule

// File: rtl/immExtend.sv
`timescale 1ns/100ps

module immExtend
  import riscvPkg::*;
(
  input  wordT    instr,
  input  immTypeT immType,
  output wordT    imm
);

  // immediate bits are scattered differently per format
  always_comb begin
    case (immType)
      immI: imm = {{20{instr[31]}}, instr[31:20]};
      immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      // branch offset is in half-words, low bit always zero
      immB: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      immJ: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

// File: rtl/riscvPkg.sv
`include "riscv_consts.svh"

package riscvPkg;

  typedef logic [`XLEN-1:0] wordT;           // data or address word
  typedef logic [`REG_ADDR_BITS-1:0] regAddrT;

  // ALU operations, gaps are unused codes
  typedef enum logic [2:0] {
    aluAdd = 3'b000,
    aluSub = 3'b001,
    aluAnd = 3'b010,
    aluOr  = 3'b011,
    aluSlt = 3'b101
  } aluOpT;

  // writeback result source
  typedef enum logic [1:0] {
    resultAlu     = 2'b00,
    resultMem     = 2'b01,
    resultPcPlus4 = 2'b10
  } resultSrcT;

  typedef enum logic [1:0] {
    immI = 2'b00,
    immS = 2'b01,
    immB = 2'b10,
    immJ = 2'b11
  } immTypeT;

  // operand forwarding into execute
  typedef enum logic [1:0] {
    fwdNone = 2'b00,
    fwdWb   = 2'b01,
    fwdMem  = 2'b10
  } forwardSelT;

endpackage

// File: rtl/riscv_consts.svh
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// datapath widths
`define XLEN          32
`define REG_COUNT     32
`define REG_ADDR_BITS 5

// fetch advances one word per instruction
`define PC_STEP 4

// major opcodes of the supported subset
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111

// funct3 for the ALU class
`define F3_ADDSUB 3'b000
`define F3_SLT    3'b010
`define F3_OR     3'b110
`define F3_AND    3'b111

// data memory depth in words
`define DMEM_WORDS 64

`endif
